//--- files.f
+incdir+test
logic/spiSlavePkg.sv
logic/spiFrameRx.sv
logic/spiCmdMux.sv
logic/csrRegFile.sv
logic/spiSlaveTop.sv
test/spiSlaveTb.sv

//--- logic/csrRegFile.sv
// CSR bank behind the SPI slave; clocked write port and combinational read port
`timescale 1ns/10ps
module csrRegFile #(
	parameter int csrAdrsBits = 4
)(
	input  logic                    iSysClk,
	input  logic                    arstN,
	input  spiSlavePkg::wordT       wd,
	input  logic [csrAdrsBits-1:0]  adrs,
	input  logic                    wEd,
	output spiSlavePkg::wordT       rd
);
	import spiSlavePkg::*;

	// Registers addressed by the low address bits
	localparam int regCount = 2 ** csrAdrsBits;

	wordT regs [regCount];

	// --------------------------------------------------------------------------
	// Write port
	// --------------------------------------------------------------------------
	// All registers come out of reset as zero
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wEd)
		begin
			// Takes effect on this edge
			regs[adrs] <= wd;
		end
	end

	// --------------------------------------------------------------------------
	// Read port
	// --------------------------------------------------------------------------
	// Same address as the write port
	// New value visible the cycle after the write
	assign rd = regs[adrs];

endmodule

//--- logic/spiCmdMux.sv
// Request decoder; registers each SPI request onto the CSR write port or the UFI write bus
`timescale 1ns/10ps
module spiCmdMux #(
	parameter int csrAdrsBits = 4,
	parameter int ufiWidth    = 16
)(
	input  logic                     iSysClk,
	input  logic                     arstN,
	input  spiSlavePkg::spiReqT      req,
	output spiSlavePkg::wordT        rdData,
	input  spiSlavePkg::wordT        csrRd,
	output spiSlavePkg::wordT        csrWd,
	output logic [csrAdrsBits-1:0]   csrAdrs,
	output logic                     csrWEd,
	output logic [ufiWidth-1:0]      ufiWd,
	output spiSlavePkg::ufiCtlT      ufiCtl
);
	import spiSlavePkg::*;

	logic csrStb;
	logic ufiStb;
	adrsT ufiAdrs;
	logic ufiWEd;
	logic ufiWVd;

	// Strobe decode by command
	assign csrStb = req.ed && (req.cmd == cmdCsrWr);
	assign ufiStb = req.ed && (req.cmd == cmdUfiWr);

	// CSR read data goes back unregistered
	assign rdData = csrRd;

	// --------------------------------------------------------------------------
	// Data and address, one cycle to line up with the strobes
	// --------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		// Low CSR address bits only
		csrWd   <= req.data;
		csrAdrs <= req.adrs[csrAdrsBits-1:0];
		// UFI data is the low part of the word
		ufiWd   <= req.data[ufiWidth-1:0];
		ufiAdrs <= req.adrs;
	end

	// --------------------------------------------------------------------------
	// Write strobes and UFI transfer period
	// --------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			csrWEd <= 1'b0;
			ufiWEd <= 1'b0;
			ufiWVd <= 1'b0;
		end
		else
		begin
			csrWEd <= csrStb;
			ufiWEd <= ufiStb;
			// Open while words remain, close on the last one
			if (ufiStb)
				ufiWVd <= (req.dLen != '0);
		end
	end

	assign ufiCtl = '{adrs: ufiAdrs, wEd: ufiWEd, wVd: ufiWVd};

	// One target per request
	assert property (@(posedge iSysClk) disable iff (!arstN) !(csrWEd && ufiCtl.wEd));

endmodule

//--- logic/spiFrameRx.sv
// SPI mode 0 frame receiver; samples the pins on iSysClk and issues one request per data word
`timescale 1ns/10ps
module spiFrameRx (
	input  logic                 iSysClk,
	input  logic                 arstN,
	input  logic                 sclk,
	input  logic                 mosi,
	input  logic                 csN,
	output logic                 miso,
	input  spiSlavePkg::wordT    rdData,
	output spiSlavePkg::spiReqT  req
);
	import spiSlavePkg::*;

	localparam int cntBits = $clog2(hdrBits);

	// --------------------------------------------------------------------------
	// Pin synchronizers and edge detect
	// --------------------------------------------------------------------------
	logic [1:0] sclkSync;
	logic [1:0] mosiSync;
	logic [1:0] csnSync;
	logic       sclkPrev;
	logic       csnPrev;
	logic       sclkRise;
	logic       sclkFall;
	logic       csnFall;
	logic       csnHigh;

	// Frame state
	rxStateT              state;
	logic [cntBits-1:0]   bitCnt;
	dLenT                 wordsLeft;
	cmdT                  cmdR;
	adrsT                 adrsCnt;
	logic [hdrBits-1:0]   hdrSh;
	logic [hdrBits-1:0]   hdrNext;
	wordT                 dataSh;
	wordT                 dataNext;
	cmdT                  hdrCmd;
	adrsT                 hdrAdrs;
	dLenT                 hdrDLen;
	dLenT                 hdrWords;
	logic                 hdrDone;
	logic                 wordDone;

	// Read data path
	logic                 txLoad;
	wordT                 txSh;

	// Registered request fields
	cmdT                  reqCmd;
	adrsT                 reqAdrs;
	wordT                 reqData;
	dLenT                 reqDLen;
	logic                 reqEd;

	// Idle levels: SCLK low, CSN high
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			sclkSync <= 2'b00;
			mosiSync <= 2'b00;
			csnSync  <= 2'b11;
			sclkPrev <= 1'b0;
			csnPrev  <= 1'b1;
		end
		else
		begin
			sclkSync <= {sclkSync[0], sclk};
			mosiSync <= {mosiSync[0], mosi};
			csnSync  <= {csnSync[0], csN};
			sclkPrev <= sclkSync[1];
			csnPrev  <= csnSync[1];
		end
	end

	assign sclkRise = sclkSync[1] & ~sclkPrev;
	assign sclkFall = ~sclkSync[1] & sclkPrev;
	assign csnFall  = csnPrev & ~csnSync[1];
	assign csnHigh  = csnSync[1];

	// --------------------------------------------------------------------------
	// Shift paths and header decode
	// --------------------------------------------------------------------------
	assign hdrNext = {hdrSh[hdrBits-2:0], mosiSync[1]};
	assign dataNext = {dataSh[wordBits-2:0], mosiSync[1]};
	assign {hdrCmd, hdrAdrs, hdrDLen} = hdrNext;

	// CSR frames carry exactly one word
	assign hdrWords = ((hdrCmd == cmdUfiWr) || (hdrCmd == cmdRsvd)) ? hdrDLen : dLenT'(1);

	assign hdrDone = (state == stHdr) && sclkRise && !csnHigh &&
		(bitCnt == cntBits'(hdrBits - 1));
	assign wordDone = (state == stData) && sclkRise && !csnHigh &&
		(bitCnt == cntBits'(wordBits - 1));

	// --------------------------------------------------------------------------
	// Frame FSM
	// --------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state     <= stIdle;
			bitCnt    <= '0;
			wordsLeft <= '0;
			cmdR      <= cmdCsrRd;
			adrsCnt   <= '0;
			reqEd     <= 1'b0;
		end
		else
		begin
			reqEd <= wordDone;
			// Early CSN rise drops the frame
			if (csnHigh)
			begin
				state  <= stIdle;
				bitCnt <= '0;
			end
			else
			begin
				case (state)
					stIdle:
					begin
						if (csnFall)
						begin
							state  <= stHdr;
							bitCnt <= '0;
						end
					end
					stHdr:
					begin
						if (hdrDone)
						begin
							bitCnt    <= '0;
							wordsLeft <= hdrWords;
							state     <= (hdrWords == '0) ? stIdle : stData;
						end
						else if (sclkRise)
						begin
							bitCnt <= bitCnt + 1'b1;
						end
					end
					stData:
					begin
						if (wordDone)
						begin
							bitCnt    <= '0;
							wordsLeft <= wordsLeft - 1'b1;
							// Last word of the frame
							if (wordsLeft == dLenT'(1))
								state <= stIdle;
						end
						else if (sclkRise)
						begin
							bitCnt <= bitCnt + 1'b1;
						end
					end
					default:
					begin
						state <= stIdle;
					end
				endcase
			end

			// Word address, header base then one up per word
			if (hdrDone)
			begin
				cmdR    <= hdrCmd;
				adrsCnt <= hdrAdrs;
			end
			else if (wordDone)
			begin
				adrsCnt <= adrsCnt + 1'b1;
			end
		end
	end

	// --------------------------------------------------------------------------
	// Shift registers and request payload
	// --------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if ((state == stHdr) && sclkRise)
			hdrSh <= hdrNext;
		if ((state == stData) && sclkRise)
			dataSh <= dataNext;
		// Address lags the counter by one, matching the strobe
		reqAdrs <= adrsCnt;
		reqCmd  <= cmdR;
		if (wordDone)
		begin
			reqData <= dataNext;
			// Words left after this one
			reqDLen <= wordsLeft - 1'b1;
		end
	end

	assign req = '{cmd: reqCmd, adrs: reqAdrs, data: reqData, dLen: reqDLen, ed: reqEd};

	// --------------------------------------------------------------------------
	// MISO for CSR reads
	// --------------------------------------------------------------------------
	// Register value is loaded on the falling edge closing the last header bit
	// Later falling edges shift it out MSB first
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			txLoad <= 1'b0;
			txSh   <= '0;
		end
		else if (csnHigh)
		begin
			txLoad <= 1'b0;
			txSh   <= '0;
		end
		else if (hdrDone)
		begin
			txLoad <= (hdrCmd == cmdCsrRd);
		end
		else if (sclkFall)
		begin
			if (txLoad)
			begin
				txLoad <= 1'b0;
				txSh   <= rdData;
			end
			else if (state == stData)
			begin
				txSh <= {txSh[wordBits-2:0], 1'b0};
			end
		end
	end

	assign miso = txSh[wordBits-1];

	// Strobe is a single cycle pulse
	assert property (@(posedge iSysClk) disable iff (!arstN) req.ed |=> !req.ed);
	// CSN high always leaves the data phase
	assert property (@(posedge iSysClk) disable iff (!arstN) csnHigh |=> (state != stData));

endmodule

//--- logic/spiSlavePkg.sv
// Shared widths, command codes, frame layout and request types; imported by every SPI slave block
package spiSlavePkg;

	// --------------------------------------------------------------------------
	// Widths with a meaning
	// --------------------------------------------------------------------------
	// SPI data word, CSR contents and read data
	typedef logic [31:0] wordT;
	// Frame address
	typedef logic [31:0] adrsT;
	// Data words still to come in a frame
	typedef logic [15:0] dLenT;
	// Frame command
	typedef logic [1:0] cmdT;

	// --------------------------------------------------------------------------
	// Command codes
	// --------------------------------------------------------------------------
	localparam cmdT cmdCsrRd = 2'd0;
	localparam cmdT cmdCsrWr = 2'd1;
	// Received and dropped
	localparam cmdT cmdRsvd  = 2'd2;
	localparam cmdT cmdUfiWr = 2'd3;

	// --------------------------------------------------------------------------
	// Frame layout
	// --------------------------------------------------------------------------
	// Header is cmd, then adrs, then dLen, MSB first
	localparam int hdrBits  = 50;
	localparam int wordBits = $bits(wordT);

	// One request per completed data word
	typedef struct packed {
		cmdT  cmd;
		adrsT adrs;
		wordT data;
		dLenT dLen;
		logic ed;
	} spiReqT;

	// UFI write control, data travels beside it
	typedef struct packed {
		adrsT adrs;
		logic wEd;
		logic wVd;
	} ufiCtlT;

	// Frame receiver states
	typedef enum logic [1:0] {stIdle, stHdr, stData} rxStateT;

endpackage

//--- logic/spiSlaveTop.sv
// SPI slave front end top level; connects frame receiver, command mux and CSR bank
`timescale 1ns/10ps
module spiSlaveTop #(
	parameter int csrAdrsBits = 4,
	parameter int ufiWidth    = 16
)(
	input  logic                 iSysClk,
	input  logic                 arstN,
	// SPI pins
	input  logic                 sclk,
	input  logic                 mosi,
	input  logic                 csN,
	output logic                 miso,
	// UFI write bus, sink outside
	output logic [ufiWidth-1:0]  ufiWd,
	output spiSlavePkg::ufiCtlT  ufiCtl
);
	import spiSlavePkg::*;

	// Receiver to mux
	spiReqT                 req;
	wordT                   rdData;
	// Mux to CSR bank
	wordT                   csrRd;
	wordT                   csrWd;
	logic [csrAdrsBits-1:0] csrAdrs;
	logic                   csrWEd;

	// --------------------------------------------------------------------------
	// Producer
	// --------------------------------------------------------------------------
	spiFrameRx i_spiFrameRx (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.sclk    (sclk),
		.mosi    (mosi),
		.csN     (csN),
		.miso    (miso),
		.rdData  (rdData),
		.req     (req)
	);

	// --------------------------------------------------------------------------
	// Command mux
	// --------------------------------------------------------------------------
	spiCmdMux #(
		.csrAdrsBits (csrAdrsBits),
		.ufiWidth    (ufiWidth)
	) i_spiCmdMux (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.req     (req),
		.rdData  (rdData),
		.csrRd   (csrRd),
		.csrWd   (csrWd),
		.csrAdrs (csrAdrs),
		.csrWEd  (csrWEd),
		.ufiWd   (ufiWd),
		.ufiCtl  (ufiCtl)
	);

	// --------------------------------------------------------------------------
	// CSR bank
	// --------------------------------------------------------------------------
	csrRegFile #(
		.csrAdrsBits (csrAdrsBits)
	) i_csrRegFile (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.wd      (csrWd),
		.adrs    (csrAdrs),
		.wEd     (csrWEd),
		.rd      (csrRd)
	);

endmodule

//--- test/spiSlaveTbTasks.svh
// SPI master driver, directed tests and compare tasks; included inside the spiSlaveTb module body

	// --------------------------------------------------------------------------
	// SPI master
	// --------------------------------------------------------------------------
	// Step to 1 ns after a rising clock edge
	task automatic tick(input int n);
		repeat (n)
		begin
			@(posedge iSysClk);
			#1;
		end
	endtask

	// Mode 0, MOSI set while SCLK low, MISO taken just before the rise
	task automatic shiftBit(input logic outBit, output logic inBit);
		mosi = outBit;
		tick(halfBit);
		inBit = miso;
		sclk = 1'b1;
		tick(halfBit);
		sclk = 1'b0;
	endtask

	// Whole frame, cut after stopBit bits; rxWord holds the last 32 MISO bits
	task automatic runFrame(input cmdT cmd, input adrsT adrs, input wordT words[$],
		input int stopBit, output wordT rxWord);
		logic [hdrBits-1:0] hdr;
		logic               bits[$];
		logic               b;
		hdr = {cmd, adrs, dLenT'(words.size())};
		rxWord = '0;
		for (int i = hdrBits - 1; i >= 0; i--)
			bits.push_back(hdr[i]);
		foreach (words[w])
			for (int i = wordBits - 1; i >= 0; i--)
				bits.push_back(words[w][i]);
		while (bits.size() > stopBit)
			void'(bits.pop_back());
		csN = 1'b0;
		tick(2);
		foreach (bits[i])
		begin
			shiftBit(bits[i], b);
			rxWord = {rxWord[wordBits-2:0], b};
		end
		tick(halfBit);
		csN = 1'b1;
		tick(2 * halfBit);
	endtask

	// Only the low CSR address bits select a register
	function automatic int csrIndex(input adrsT adrs);
		return int'(adrs[csrAdrsBits-1:0]);
	endfunction

	task automatic csrWrite(input adrsT adrs, input wordT data);
		wordT one[$];
		wordT rx;
		one.push_back(data);
		runFrame(cmdCsrWr, adrs, one, noDrop, rx);
		expCsr[csrIndex(adrs)] = data;
	endtask

	task automatic csrRead(input adrsT adrs, output wordT data);
		wordT one[$];
		one.push_back('0);
		runFrame(cmdCsrRd, adrs, one, noDrop, data);
	endtask

	// Read a range back against the model
	task automatic checkCsrs(input int lo, input int hi);
		wordT rx;
		for (int a = lo; a <= hi; a++)
		begin
			csrRead(adrsT'(a), rx);
			compareWord(expCsr[a], rx);
		end
	endtask

	task automatic waitStrobes(input int count);
		int n;
		n = 0;
		while (ufiQ.size() < count && n < 16 * halfBit)
		begin
			tick(1);
			n++;
		end
		if (ufiQ.size() != count)
			flagFailure($sformatf("expected %0d UFI strobes but saw %0d", count, ufiQ.size()));
	endtask

	// --------------------------------------------------------------------------
	// Checks and bookkeeping
	// --------------------------------------------------------------------------
	task automatic compareWord(input wordT exp, input wordT act);
		if (act !== exp)
		begin
			errCount++;
			$display("Mismatch in %s: expected %h, actual %h", curTest, exp, act);
		end
	endtask

	task automatic compareUfiWd(input logic [ufiWidth-1:0] exp, input logic [ufiWidth-1:0] act);
		if (act !== exp)
		begin
			errCount++;
			$display("Mismatch in %s: expected %h, actual %h", curTest, exp, act);
		end
	endtask

	task automatic compareAdrs(input adrsT exp, input adrsT act);
		if (act !== exp)
		begin
			errCount++;
			$display("Mismatch in %s: expected %h, actual %h", curTest, exp, act);
		end
	endtask

	task automatic compareBit(input logic exp, input logic act);
		if (act !== exp)
		begin
			errCount++;
			$display("Mismatch in %s: expected %b, actual %b", curTest, exp, act);
		end
	endtask

	task automatic flagFailure(input string msg);
		errCount++;
		$display("Error in %s: %s", curTest, msg);
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrStart = errCount;
	endtask

	task automatic endTest();
		if (errCount == testErrStart)
		begin
			passCount++;
			$display("Test %s: ok", curTest);
		end
		else
		begin
			failCount++;
			$display("Test %s: %0d errors", curTest, errCount - testErrStart);
		end
	endtask

	// --------------------------------------------------------------------------
	// Directed tests
	// --------------------------------------------------------------------------
	task automatic testResetState();
		wordT rx;
		startTest("reset state");
		compareBit(1'b0, miso);
		compareBit(1'b0, ufiCtl.wVd);
		// Spread over the bank
		for (int a = 0; a < 16; a += 5)
		begin
			csrRead(adrsT'(a), rx);
			compareWord('0, rx);
		end
		if (ufiQ.size() != 0)
			flagFailure("UFI strobe seen after reset");
		endTest();
	endtask

	task automatic testCsrReadBack();
		startTest("CSR write and read back");
		for (int a = 0; a < 4; a++)
			csrWrite(adrsT'(a), randomWord());
		checkCsrs(0, 3);
		endTest();
	endtask

	task automatic testAdrsTruncation();
		wordT w;
		wordT rx;
		startTest("address truncation");
		w = randomWord();
		csrWrite(32'h12, w);
		csrRead(32'h2, rx);
		compareWord(w, rx);
		endTest();
	endtask

	task automatic testUfiBurst();
		wordT words[$];
		wordT rx;
		adrsT base;
		startTest("UFI burst");
		base = 32'h4000_0100;
		ufiQ.delete();
		for (int i = 0; i < 5; i++)
			words.push_back(randomWord());
		runFrame(cmdUfiWr, base, words, noDrop, rx);
		waitStrobes(5);
		foreach (ufiQ[i])
		begin
			if (i < 5)
			begin
				compareAdrs(base + adrsT'(i), ufiQ[i].adrs);
				compareUfiWd(words[i][ufiWidth-1:0], ufiQ[i].wd);
				// Transfer period closes on the last word
				compareBit(i < 4, ufiQ[i].wVd);
			end
		end
		compareBit(1'b0, ufiCtl.wVd);
		checkCsrs(0, 3);
		endTest();
	endtask

	task automatic testIgnoredCmd();
		wordT words[$];
		wordT rx;
		startTest("ignored command");
		ufiQ.delete();
		words.push_back(randomWord());
		words.push_back(randomWord());
		runFrame(cmdRsvd, 32'h1, words, noDrop, rx);
		if (ufiQ.size() != 0)
			flagFailure("reserved frame produced a UFI strobe");
		checkCsrs(0, 3);
		endTest();
	endtask

	task automatic testDroppedFrame();
		wordT one[$];
		wordT rx;
		startTest("dropped frame");
		one.push_back(randomWord());
		// CSN rises halfway through the data word
		runFrame(cmdCsrWr, 32'h3, one, hdrBits + 16, rx);
		checkCsrs(3, 3);
		csrWrite(32'h3, randomWord());
		checkCsrs(3, 3);
		endTest();
	endtask

//--- test/spiSlaveTb.sv
// Testbench top for the SPI slave front end; compile with files.f and run top module spiSlaveTb
`timescale 1ns/10ps
module spiSlaveTb;
	import spiSlavePkg::*;

	// --------------------------------------------------------------------------
	// Setup and run length
	// --------------------------------------------------------------------------
	localparam int csrAdrsBits = 4;
	localparam int ufiWidth    = 16;
	localparam int resetCycles = 10;
	// SCLK half period in system clocks
	localparam int halfBit     = 4;
	// Bit count large enough to never cut a frame
	localparam int noDrop      = 1 << 20;
	localparam int csrFrame    = hdrBits + wordBits;
	// 25 CSR frames, the burst, the reserved frame, the cut frame
	localparam int totalBits   = 25 * csrFrame + (hdrBits + 5 * wordBits) +
		(hdrBits + 2 * wordBits) + (hdrBits + 16);
	localparam int cycleLimit  = totalBits * 2 * halfBit * 3 / 2 + resetCycles;

	// One UFI write seen on the bus
	typedef struct packed {
		adrsT                 adrs;
		logic [ufiWidth-1:0]  wd;
		logic                 wVd;
	} ufiBeatT;

	logic                 iSysClk;
	logic                 arstN;
	logic                 sclk;
	logic                 mosi;
	logic                 csN;
	logic                 miso;
	logic [ufiWidth-1:0]  ufiWd;
	ufiCtlT               ufiCtl;

	// Monitor queue and CSR model
	ufiBeatT              ufiQ[$];
	ufiBeatT              monBeat;
	wordT                 expCsr [2 ** csrAdrsBits];
	logic [31:0]          lfsrState = 32'd5158;
	string                curTest;
	int                   errCount = 0;
	int                   testErrStart = 0;
	int                   passCount = 0;
	int                   failCount = 0;
	int                   cycleCnt = 0;

	spiSlaveTop #(
		.csrAdrsBits (csrAdrsBits),
		.ufiWidth    (ufiWidth)
	) i_spiSlaveTop (
		.iSysClk (iSysClk),
		.arstN   (arstN),
		.sclk    (sclk),
		.mosi    (mosi),
		.csN     (csN),
		.miso    (miso),
		.ufiWd   (ufiWd),
		.ufiCtl  (ufiCtl)
	);

	// 4 ns system clock
	initial
	begin
		iSysClk = 1'b0;
		forever #2 iSysClk = ~iSysClk;
	end

	// UFI monitor, sampled mid cycle
	always @(negedge iSysClk)
	begin
		if (arstN && ufiCtl.wEd)
		begin
			monBeat.adrs = ufiCtl.adrs;
			monBeat.wd   = ufiWd;
			monBeat.wVd  = ufiCtl.wVd;
			ufiQ.push_back(monBeat);
		end
	end

	// Run length guard
	always @(posedge iSysClk)
	begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// --------------------------------------------------------------------------
	// Random data
	// --------------------------------------------------------------------------
	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic nextLfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 32'h8020_0003;
		return outBit;
	endfunction

	// One step per bit
	function automatic wordT randomWord();
		wordT w;
		for (int i = 0; i < wordBits; i++)
		begin
			w[i] = nextLfsrBit();
		end
		return w;
	endfunction

	`include "spiSlaveTbTasks.svh"

	// --------------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------------
	initial
	begin
		sclk  = 1'b0;
		mosi  = 1'b0;
		csN   = 1'b1;
		arstN = 1'b0;
		foreach (expCsr[i])
			expCsr[i] = '0;
		tick(resetCycles);
		arstN = 1'b1;
		tick(2);
		testResetState();
		testCsrReadBack();
		testAdrsTruncation();
		testUfiBurst();
		testIgnoredCmd();
		testDroppedFrame();
		$display("Summary: %0d tests ok, %0d tests failed, %0d errors",
			passCount, failCount, errCount);
		if (failCount == 0 && errCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
